// ==== bench/fetch_checker.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_checker (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_wb_cyc,
    input  logic                   i_wb_stb,
    input  logic [`FETCH_XLEN-1:0] i_wb_adr,
    input  logic                   i_wb_ack,
    input  logic                   i_redirect,
    input  logic [`FETCH_XLEN-1:0] i_redirect_pc,
    input  logic                   i_dec_valid,
    input  logic [`FETCH_XLEN-1:0] i_dec_pc,
    input  logic [`FETCH_XLEN-1:0] i_dec_ir0,
    input  logic [`FETCH_XLEN-1:0] i_dec_ir1,
    input  logic [1:0]             i_dec_mask,
    input  logic                   i_dec_ready,
    input  logic [`FETCH_XLEN-1:0] i_exp_ir0,   // reference words at the expected pc
    input  logic [`FETCH_XLEN-1:0] i_exp_ir1,
    output logic [`FETCH_XLEN-1:0] o_exp_pc,
    output int                     o_xfer_count,
    output int                     o_value_errors,
    output int                     o_protocol_errors
);

    fetch_pkg::fetch_addr_u exp_pc;
    fetch_pkg::fetch_addr_u bus_pc;         // pair the bus is fetching
    logic [1:0]             exp_mask;
    logic [1:0]             bus_mask;
    logic [`FETCH_XLEN-1:0] bus_last_adr;   // address of the pair's final word
    logic                   stale_cycle;    // bus cycle left over from before a redirect
    logic                   pair_in;        // final word of a wanted pair acked
    logic                   pair_out;
    logic                   after_redirect;
    logic                   prev_stb;
    logic                   prev_ack;
    logic [`FETCH_XLEN-1:0] prev_adr;
    int                     waiting;        // pairs fetched and not yet taken by decode
    int                     value_errors = 0;
    int                     protocol_errors = 0;
    int                     xfer_count = 0;

    // last word of a line goes alone
    function automatic logic [1:0] pair_mask_of(input fetch_pkg::fetch_addr_u pc);
        return (pc.fields.word == `FETCH_WORD_BITS'(`FETCH_LINE_WORDS - 1)) ? 2'b01 : 2'b11;
    endfunction

    assign exp_mask     = pair_mask_of(exp_pc);
    assign bus_mask     = pair_mask_of(bus_pc);
    assign bus_last_adr = bus_pc.raw + (bus_mask[1] ? 32'd4 : 32'd0);

    assign o_exp_pc          = exp_pc.raw;
    assign o_xfer_count      = xfer_count;
    assign o_value_errors    = value_errors;
    assign o_protocol_errors = protocol_errors;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic protocol_error(input string what);
        $display("bus protocol error at %0t: %s", $time, what);
        protocol_errors = protocol_errors + 1;
    endtask

    ////////////////////////////////////////////////////////////////////
    // decode side and bus checks
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!i_arst_n) begin
            exp_pc.raw     <= `FETCH_RESET_PC;
            bus_pc.raw     <= `FETCH_RESET_PC;
            after_redirect <= 1'b0;
            stale_cycle    <= 1'b0;
            waiting        <= 0;
            prev_stb       <= 1'b0;
            prev_ack       <= 1'b0;
            prev_adr       <= '0;
        end else begin
            pair_in  = i_wb_stb && i_wb_ack && !stale_cycle && (i_wb_adr === bus_last_adr);
            pair_out = i_dec_valid && i_dec_ready;

            if (i_redirect) begin
                // a transfer in this cycle is flushed with decode
                exp_pc.raw     <= {i_redirect_pc[31:2], 2'b00};
                bus_pc.raw     <= {i_redirect_pc[31:2], 2'b00};
                after_redirect <= 1'b1;
                stale_cycle    <= i_wb_stb && !i_wb_ack;    // its ack is still to come
                waiting        <= 0;
            end else begin
                if (pair_out) begin
                    check_value(after_redirect ? "redirect" : "sequence", exp_pc.raw, i_dec_pc);
                    check_value("mask", {30'd0, exp_mask}, {30'd0, i_dec_mask});
                    check_value("ir0", i_exp_ir0, i_dec_ir0);
                    if (exp_mask[1]) begin
                        check_value("ir1", i_exp_ir1, i_dec_ir1);
                    end
                    exp_pc.raw     <= exp_pc.raw + (exp_mask[1] ? 32'd8 : 32'd4);
                    after_redirect <= 1'b0;
                    xfer_count = xfer_count + 1;
                end
                if (pair_in) begin
                    bus_pc.raw <= bus_pc.raw + (bus_mask[1] ? 32'd8 : 32'd4);
                end
                if (i_wb_stb && i_wb_ack) begin
                    stale_cycle <= 1'b0;
                end
                waiting <= waiting + (pair_in ? 1 : 0) - (pair_out ? 1 : 0);
            end

            if (i_wb_stb && !i_wb_cyc) begin
                protocol_error("strobe is high while cycle is low");
            end
            if (prev_stb && !prev_ack && (!i_wb_stb || (i_wb_adr !== prev_adr))) begin
                protocol_error("strobe or address changed before the ack came");
            end
            if (i_wb_cyc && (waiting >= `FETCH_QUEUE_DEPTH)) begin
                protocol_error("a bus cycle runs while the fetch queue is full");
            end
            prev_stb <= i_wb_stb;
            prev_ack <= i_wb_ack;
            prev_adr <= i_wb_adr;
        end
    end

endmodule

// ==== bench/fetch_tb.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_tb;

    localparam int N_XFERS     = 2000;
    localparam int CYCLE_LIMIT = N_XFERS * 40;   // about 40 cycles per pair covers waits and stalls

    logic                   clk = 1'b0;
    logic                   i_arst_n;
    logic [`FETCH_XLEN-1:0] i_wb_dat;
    logic                   i_wb_ack;
    logic                   i_redirect;
    logic [`FETCH_XLEN-1:0] i_redirect_pc;
    logic                   i_dec_ready;
    logic                   o_wb_cyc;
    logic                   o_wb_stb;
    logic [`FETCH_XLEN-1:0] o_wb_adr;
    logic                   o_dec_valid;
    logic [`FETCH_XLEN-1:0] o_dec_pc;
    logic [`FETCH_XLEN-1:0] o_dec_ir0;
    logic [`FETCH_XLEN-1:0] o_dec_ir1;
    logic [1:0]             o_dec_mask;

    logic [31:0]            lfsr = 32'he1ecb759;
    logic [31:0]            rnd;
    logic                   slave_busy = 1'b0;
    logic [1:0]             wait_left = 2'd0;
    int                     redirect_gap = 30;
    int                     stall_left = 0;
    int                     cycles = 0;
    int                     xfer_count;
    int                     value_errors;
    int                     protocol_errors;
    logic [`FETCH_XLEN-1:0] exp_pc;
    logic [`FETCH_XLEN-1:0] exp_ir0;
    logic [`FETCH_XLEN-1:0] exp_ir1;
    logic                   timed_out;

    always #2 clk = ~clk;

    // memory image is the address rotated left by 7 and xored
    function automatic logic [31:0] instr_at(input logic [31:0] adr);
        return {adr[24:0], adr[31:25]} ^ 32'h5a5a_c3c3;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    assign exp_ir0 = instr_at(exp_pc);
    assign exp_ir1 = instr_at(exp_pc + 32'd4);

    fetch_top dut (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_adr      (o_wb_adr),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_dec_valid   (o_dec_valid),
        .o_dec_pc      (o_dec_pc),
        .o_dec_ir0     (o_dec_ir0),
        .o_dec_ir1     (o_dec_ir1),
        .o_dec_mask    (o_dec_mask),
        .i_dec_ready   (i_dec_ready)
    );

    fetch_checker u_checker (
        .clk               (clk),
        .i_arst_n          (i_arst_n),
        .i_wb_cyc          (o_wb_cyc),
        .i_wb_stb          (o_wb_stb),
        .i_wb_adr          (o_wb_adr),
        .i_wb_ack          (i_wb_ack),
        .i_redirect        (i_redirect),
        .i_redirect_pc     (i_redirect_pc),
        .i_dec_valid       (o_dec_valid),
        .i_dec_pc          (o_dec_pc),
        .i_dec_ir0         (o_dec_ir0),
        .i_dec_ir1         (o_dec_ir1),
        .i_dec_mask        (o_dec_mask),
        .i_dec_ready       (i_dec_ready),
        .i_exp_ir0         (exp_ir0),
        .i_exp_ir1         (exp_ir1),
        .o_exp_pc          (exp_pc),
        .o_xfer_count      (xfer_count),
        .o_value_errors    (value_errors),
        .o_protocol_errors (protocol_errors)
    );

    ////////////////////////////////////////////////////////////////////
    // stimulus and wishbone slave
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (i_arst_n) begin
            if (i_wb_ack) begin
                i_wb_ack <= 1'b0;               // single-cycle ack
            end else if (o_wb_stb) begin
                if (!slave_busy) begin
                    take_bits(2, rnd);          // 0 to 3 wait states
                    wait_left  <= rnd[1:0];
                    slave_busy <= 1'b1;
                end else if (wait_left == 2'd0) begin
                    i_wb_ack   <= 1'b1;
                    i_wb_dat   <= instr_at(o_wb_adr);
                    slave_busy <= 1'b0;
                end else begin
                    wait_left <= wait_left - 2'd1;
                end
            end

            if (redirect_gap == 0) begin
                take_bits(12, rnd);
                i_redirect    <= 1'b1;
                i_redirect_pc <= `FETCH_RESET_PC + {20'd0, rnd[11:0]};  // 4 KB window, any byte
                take_bits(5, rnd);
                redirect_gap  <= 24 + int'(rnd[4:0]);
            end else begin
                i_redirect   <= 1'b0;
                redirect_gap <= redirect_gap - 1;
            end

            // ready about 3 of 4 cycles with a long stall now and then
            if (stall_left != 0) begin
                i_dec_ready <= 1'b0;
                stall_left  <= stall_left - 1;
            end else begin
                take_bits(6, rnd);
                if (rnd[5:0] == 6'd0) begin
                    stall_left <= 30;
                end
                take_bits(2, rnd);
                i_dec_ready <= (rnd[1:0] != 2'b00);
            end
        end
    end

    initial begin
        i_arst_n      = 1'b0;
        i_wb_dat      = '0;
        i_wb_ack      = 1'b0;
        i_redirect    = 1'b0;
        i_redirect_pc = '0;
        i_dec_ready   = 1'b0;
        repeat (3) @(posedge clk);
        i_arst_n <= 1'b1;
        while ((xfer_count < N_XFERS) && (cycles < CYCLE_LIMIT)) begin
            @(posedge clk);
        end
        timed_out = (xfer_count < N_XFERS);
        if (timed_out) begin
            $display("timeout: only %0d of %0d transfers seen after %0d cycles",
                     xfer_count, N_XFERS, cycles);
        end
        $display("transfers %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 xfer_count, value_errors, protocol_errors, timed_out ? 1 : 0);
        if ((value_errors == 0) && (protocol_errors == 0) && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== include/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////////////////////////////////////////////////////////
// fetch front end geometry
////////////////////////////////////////////////////////////////////////

// address and instruction word width
`define FETCH_XLEN        32

// first fetch after reset
`define FETCH_RESET_PC    32'h1c000000

`define FETCH_QUEUE_DEPTH 4     // fetch pairs held before decode

// 16-byte lines, four words each
`define FETCH_WORD_BITS   2
`define FETCH_LINE_WORDS  4

`endif

// ==== run.sh ====
#!/bin/bash
# build the fetch front end testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f src.f --top-module fetch_tb -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0

// ==== src.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/wb_fetch_master.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// ==== verilog/fetch_pc_gen.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_pc_gen (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_pair_done,
    input  logic                   i_redirect,
    input  logic [`FETCH_XLEN-1:0] i_redirect_pc,
    output fetch_pkg::fetch_addr_u o_pc,
    output logic [1:0]             o_pair_mask
);

    fetch_pkg::fetch_addr_u pc_q;
    fetch_pkg::fetch_addr_u pc_next;
    logic                   last_word;

    // pc in the last word of its line, so only one word is fetched
    assign last_word = (pc_q.fields.word == `FETCH_WORD_BITS'(`FETCH_LINE_WORDS - 1));

    assign o_pair_mask = last_word ? 2'b01 : 2'b11;  // bit 0 = ir0, bit 1 = ir1
    assign o_pc        = pc_q;

    ////////////////////////////////////////////////////////////////////////
    // next pc
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        pc_next = pc_q;
        if (i_redirect) begin                   // redirect wins over advance
            pc_next.raw             = i_redirect_pc;
            pc_next.fields.byte_off = 2'b00;    // word aligned target
        end else if (i_pair_done) begin
            // a pair never crosses a line
            pc_next.raw = pc_q.raw + (last_word ? `FETCH_XLEN'(4) : `FETCH_XLEN'(8));
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q.raw <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

// ==== verilog/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////
    // fetch address
    ////////////////////////////////////////////////////////////////////////

    // the same 32-bit word is read in two ways:
    // raw goes straight onto the bus, while fields feeds the next-PC rule
    // and the line boundary check
    typedef union packed {
        logic [`FETCH_XLEN-1:0] raw;            // bus address
        struct packed {
            // line index above the 16-byte line
            logic [`FETCH_XLEN-`FETCH_WORD_BITS-3:0] line;
            logic [`FETCH_WORD_BITS-1:0]             word;      // word in line
            logic [1:0]                              byte_off;  // always 0 on fetch
        } fields;
    } fetch_addr_u;

endpackage

// ==== verilog/fetch_queue.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_queue #(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH    // power of two, 2 or more
) (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_push,
    input  logic [`FETCH_XLEN-1:0] i_push_pc,
    input  logic [`FETCH_XLEN-1:0] i_push_ir0,
    input  logic [`FETCH_XLEN-1:0] i_push_ir1,
    input  logic [1:0]             i_push_mask,
    input  logic                   i_flush,
    input  logic                   i_dec_ready,
    output logic                   o_full,
    output logic                   o_dec_valid,
    output logic [`FETCH_XLEN-1:0] o_dec_pc,
    output logic [`FETCH_XLEN-1:0] o_dec_ir0,
    output logic [`FETCH_XLEN-1:0] o_dec_ir1,
    output logic [1:0]             o_dec_mask
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [`FETCH_XLEN-1:0] pc_mem   [DEPTH];
    logic [`FETCH_XLEN-1:0] ir0_mem  [DEPTH];
    logic [`FETCH_XLEN-1:0] ir1_mem  [DEPTH];
    logic [1:0]             mask_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;        // one bit wider to tell full from empty
    logic             pop;
    logic             wr_en;

    assign o_full      = (count == (PTR_W+1)'(DEPTH));
    assign o_dec_valid = (count != '0);

    assign pop   = o_dec_valid && i_dec_ready;
    assign wr_en = i_push && (!o_full || pop);  // a full queue takes a push only on pop

    ////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            pc_mem[wr_ptr]   <= i_push_pc;
            ir0_mem[wr_ptr]  <= i_push_ir0;
            ir1_mem[wr_ptr]  <= i_push_ir1;
            mask_mem[wr_ptr] <= i_push_mask;
        end
    end

    // head entry straight to decode
    assign o_dec_pc   = pc_mem[rd_ptr];
    assign o_dec_ir0  = ir0_mem[rd_ptr];
    assign o_dec_ir1  = ir1_mem[rd_ptr];
    assign o_dec_mask = mask_mem[rd_ptr];

    ////////////////////////////////////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            // redirect drops every queued pair
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   i_arst_n,

    // wishbone classic read master
    output logic                   o_wb_cyc,
    output logic                   o_wb_stb,
    output logic [`FETCH_XLEN-1:0] o_wb_adr,
    input  logic [`FETCH_XLEN-1:0] i_wb_dat,
    input  logic                   i_wb_ack,

    // branch redirect
    input  logic                   i_redirect,
    input  logic [`FETCH_XLEN-1:0] i_redirect_pc,

    // decode side
    output logic                   o_dec_valid,
    output logic [`FETCH_XLEN-1:0] o_dec_pc,
    output logic [`FETCH_XLEN-1:0] o_dec_ir0,
    output logic [`FETCH_XLEN-1:0] o_dec_ir1,
    output logic [1:0]             o_dec_mask,
    input  logic                   i_dec_ready
);

    fetch_pkg::fetch_addr_u fetch_pc;
    logic [1:0]             pair_mask;
    logic                   pair_done;
    logic                   queue_full;
    logic [`FETCH_XLEN-1:0] push_pc;
    logic [`FETCH_XLEN-1:0] push_ir0;
    logic [`FETCH_XLEN-1:0] push_ir1;
    logic [1:0]             push_mask;

    ////////////////////////////////////////////////////////////////////////
    // pc generator, bus engine, queue
    ////////////////////////////////////////////////////////////////////////

    fetch_pc_gen u_pc_gen (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_pair_done   (pair_done),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_pc          (fetch_pc),
        .o_pair_mask   (pair_mask)
    );

    wb_fetch_master u_wb_master (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_pc         (fetch_pc),
        .i_pair_mask  (pair_mask),
        .i_queue_full (queue_full),   // back-pressure from decode
        .i_redirect   (i_redirect),
        .i_wb_dat     (i_wb_dat),
        .i_wb_ack     (i_wb_ack),
        .o_wb_cyc     (o_wb_cyc),
        .o_wb_stb     (o_wb_stb),
        .o_wb_adr     (o_wb_adr),
        .o_pair_done  (pair_done),
        .o_push_pc    (push_pc),
        .o_push_ir0   (push_ir0),
        .o_push_ir1   (push_ir1),
        .o_push_mask  (push_mask)
    );

    fetch_queue u_queue (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_push      (pair_done),
        .i_push_pc   (push_pc),
        .i_push_ir0  (push_ir0),
        .i_push_ir1  (push_ir1),
        .i_push_mask (push_mask),
        .i_flush     (i_redirect),     // decode is flushed as well
        .i_dec_ready (i_dec_ready),
        .o_full      (queue_full),
        .o_dec_valid (o_dec_valid),
        .o_dec_pc    (o_dec_pc),
        .o_dec_ir0   (o_dec_ir0),
        .o_dec_ir1   (o_dec_ir1),
        .o_dec_mask  (o_dec_mask)
    );

endmodule

// ==== verilog/wb_fetch_master.sv ====
`timescale 1ns/100ps
`include "fetch_macros.svh"

module wb_fetch_master (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  fetch_pkg::fetch_addr_u i_pc,
    input  logic [1:0]             i_pair_mask,
    input  logic                   i_queue_full,
    input  logic                   i_redirect,
    input  logic [`FETCH_XLEN-1:0] i_wb_dat,
    input  logic                   i_wb_ack,
    output logic                   o_wb_cyc,
    output logic                   o_wb_stb,
    output logic [`FETCH_XLEN-1:0] o_wb_adr,
    output logic                   o_pair_done,
    output logic [`FETCH_XLEN-1:0] o_push_pc,
    output logic [`FETCH_XLEN-1:0] o_push_ir0,
    output logic [`FETCH_XLEN-1:0] o_push_ir1,
    output logic [1:0]             o_push_mask
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FIRST,       // read at pc
        ST_SECOND,      // read at pc + 4
        ST_DRAIN        // redirected, wait out the open cycle
    } state_t;

    state_t                 state_q;
    state_t                 state_d;
    fetch_pkg::fetch_addr_u adr_q;
    fetch_pkg::fetch_addr_u adr_d;
    logic [`FETCH_XLEN-1:0] ir0_q;
    logic                   start;
    logic                   last_ack;

    assign start = (state_q == ST_IDLE) && !i_redirect && !i_queue_full;

    // final ack of a pair that is still wanted
    assign last_ack = i_wb_ack && !i_redirect &&
                      (((state_q == ST_FIRST) && !i_pair_mask[1]) ||
                       (state_q == ST_SECOND));

    ////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        adr_d   = adr_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_FIRST;
                    adr_d   = i_pc;
                end
            end
            ST_FIRST: begin
                if (i_wb_ack) begin
                    if (i_redirect || !i_pair_mask[1]) begin
                        state_d = ST_IDLE;
                    end else begin
                        // second word sits in the same line
                        state_d           = ST_SECOND;
                        adr_d.fields.word = adr_q.fields.word + `FETCH_WORD_BITS'(1);
                    end
                end else if (i_redirect) begin
                    state_d = ST_DRAIN;     // strobe cannot be dropped mid-cycle
                end
            end
            ST_SECOND: begin
                if (i_wb_ack) begin
                    state_d = ST_IDLE;
                end else if (i_redirect) begin
                    state_d = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (i_wb_ack) begin
                    state_d = ST_IDLE;      // data thrown away
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address and first word hold no control state
    always_ff @(posedge clk) begin
        adr_q <= adr_d;
        if ((state_q == ST_FIRST) && i_wb_ack) begin
            ir0_q <= i_wb_dat;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // bus and queue side
    ////////////////////////////////////////////////////////////////////////

    // single reads, so cyc and stb rise and fall together
    assign o_wb_cyc = (state_q != ST_IDLE);
    assign o_wb_stb = (state_q != ST_IDLE);
    assign o_wb_adr = adr_q.raw;

    // pc only moves after a push or a redirect, so it is still the pair's pc
    assign o_pair_done = last_ack;
    assign o_push_pc   = i_pc.raw;
    assign o_push_mask = i_pair_mask;
    assign o_push_ir0  = (state_q == ST_SECOND) ? ir0_q : i_wb_dat;
    assign o_push_ir1  = (state_q == ST_SECOND) ? i_wb_dat : '0;  // zero when single

endmodule
